//--- Bender.yml
package:
  name: axi_perf_mem

sources:
  - rtl/axi_defs_pkg.sv
  - rtl/perf_defs_pkg.sv
  - rtl/axi_burst_mem.sv
  - rtl/axi_traffic_gen.sv
  - rtl/perf_counters.sv
  - rtl/perf_reporter.sv
  - rtl/uart_tx.sv
  - rtl/axi_perf_mem.sv
  - target: test
    files:
      - tests/tb_axi_perf_mem.sv

//--- rtl/axi_burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_mem (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     awvalid,
  input  logic [axi_defs_pkg::axi_addr_width-1:0]  awaddr,
  input  logic [7:0]                               awlen,
  input  logic [2:0]                               awsize,
  input  logic [1:0]                               awburst,
  output logic                                     awready,
  input  logic                                     wvalid,
  input  logic [axi_defs_pkg::axi_data_width-1:0]  wdata,
  input  logic [axi_defs_pkg::axi_strb_width-1:0]  wstrb,
  input  logic                                     wlast,
  output logic                                     wready,
  output logic                                     bvalid,
  output logic [1:0]                               bresp,
  input  logic                                     bready,
  input  logic                                     arvalid,
  input  logic [axi_defs_pkg::axi_addr_width-1:0]  araddr,
  input  logic [7:0]                               arlen,
  input  logic [2:0]                               arsize,
  input  logic [1:0]                               arburst,
  output logic                                     arready,
  output logic                                     rvalid,
  output logic [axi_defs_pkg::axi_data_width-1:0]  rdata,
  output logic                                     rlast,
  output logic [1:0]                               rresp,
  input  logic                                     rready
);

  logic [axi_defs_pkg::axi_data_width-1:0] mem [axi_defs_pkg::mem_words];

  // word addresses drop the byte offset bit.
  logic [axi_defs_pkg::axi_addr_width-2:0] waddr;
  logic [axi_defs_pkg::axi_addr_width-2:0] raddr;
  logic [7:0] wlen;
  logic [7:0] wcnt;
  logic [7:0] rlen;
  logic [7:0] rcnt;
  logic       w_busy;
  logic       b_pend;
  logic       r_busy;

  assign awready = !w_busy && !b_pend;
  assign wready  = w_busy;
  assign bvalid  = b_pend;
  assign bresp   = axi_defs_pkg::axi_resp_okay;
  assign arready = !r_busy;
  assign rvalid  = r_busy;
  assign rdata   = mem[raddr];
  assign rlast   = (rcnt == rlen);
  assign rresp   = axi_defs_pkg::axi_resp_okay;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_busy <= 1'b0;
      b_pend <= 1'b0;
      waddr  <= '0;
      wlen   <= '0;
      wcnt   <= '0;
    end else if (awvalid && awready) begin
      w_busy <= 1'b1;
      waddr  <= awaddr[axi_defs_pkg::axi_addr_width-1:1];
      wlen   <= awlen;
      wcnt   <= '0;
    end else if (wvalid && wready) begin
      waddr <= waddr + 1'b1;
      wcnt  <= wcnt + 8'd1;
      if (wlast) begin
        w_busy <= 1'b0;
        b_pend <= 1'b1;
      end
    end else if (bvalid && bready) begin
      b_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wvalid && wready) begin
      for (int i = 0; i < axi_defs_pkg::axi_strb_width; i++) begin
        if (wstrb[i])
          mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_busy <= 1'b0;
      raddr  <= '0;
      rlen   <= '0;
      rcnt   <= '0;
    end else if (arvalid && arready) begin
      r_busy <= 1'b1;
      raddr  <= araddr[axi_defs_pkg::axi_addr_width-1:1];
      rlen   <= arlen;
      rcnt   <= '0;
    end else if (rvalid && rready) begin
      raddr <= raddr + 1'b1;
      rcnt  <= rcnt + 8'd1;
      if (rlast)
        r_busy <= 1'b0;
    end
  end

  // the master must mark the last beat of the length it asked for.
  assert property (@(posedge clk) disable iff (!rst_n)
    (wvalid && wready) |-> (wlast == (wcnt == wlen)));

  assert property (@(posedge clk) disable iff (!rst_n)
    (awvalid && awready) |-> (awburst == axi_defs_pkg::axi_burst_incr &&
      awsize == axi_defs_pkg::axi_size_full && awlen < axi_defs_pkg::max_burst_beats &&
      int'(awaddr >> 1) + int'(awlen) < axi_defs_pkg::mem_words));

  assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid && arready) |-> (arburst == axi_defs_pkg::axi_burst_incr &&
      arsize == axi_defs_pkg::axi_size_full &&
      int'(araddr >> 1) + int'(arlen) < axi_defs_pkg::mem_words));

endmodule

`default_nettype wire

//--- rtl/axi_defs_pkg.sv
`default_nettype none

package axi_defs_pkg;

  // bus geometry of the generator to memory link.
  localparam int axi_addr_width = 8;
  localparam int axi_data_width = 16;
  localparam int axi_id_width   = 4;
  localparam int axi_strb_width = axi_data_width / 8;

  // size code for a beat that fills the whole data bus.
  localparam logic [2:0] axi_size_full = 3'b001;

  localparam logic [1:0] axi_burst_incr = 2'b01;
  localparam logic [1:0] axi_resp_okay  = 2'b00;

  // the memory holds exactly max_bursts bursts of max_burst_beats words.
  localparam int mem_words       = 128;
  localparam int max_burst_beats = 16;
  localparam int max_bursts      = 8;

endpackage

`default_nettype wire

//--- rtl/axi_perf_mem.sv
`timescale 1ns/1ps
`default_nettype none

module axi_perf_mem (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [3:0] num_bursts,
  input  logic [3:0] burst_len,
  output logic       utx_pin
);

  logic                                      awvalid;
  logic [axi_defs_pkg::axi_addr_width-1:0]   awaddr;
  logic [7:0]                                awlen;
  logic [2:0]                                awsize;
  logic [1:0]                                awburst;
  logic                                      awready;
  logic                                      wvalid;
  logic [axi_defs_pkg::axi_data_width-1:0]   wdata;
  logic [axi_defs_pkg::axi_strb_width-1:0]   wstrb;
  logic                                      wlast;
  logic                                      wready;
  logic                                      bvalid;
  logic [1:0]                                bresp;
  logic                                      bready;
  logic                                      arvalid;
  logic [axi_defs_pkg::axi_addr_width-1:0]   araddr;
  logic [7:0]                                arlen;
  logic [2:0]                                arsize;
  logic [1:0]                                arburst;
  logic                                      arready;
  logic                                      rvalid;
  logic [axi_defs_pkg::axi_data_width-1:0]   rdata;
  logic                                      rlast;
  logic [1:0]                                rresp;
  logic                                      rready;
  logic                                      wr_phase;
  logic                                      rd_phase;
  logic                                      burst_done;
  logic                                      beat_done;
  logic                                      mismatch;
  logic                                      run_done;
  logic                                      report_start;
  logic [7:0]                                bursts;
  logic [perf_defs_pkg::beat_cnt_width-1:0]  beats;
  logic [perf_defs_pkg::beat_cnt_width-1:0]  mismatches;
  logic [perf_defs_pkg::cycle_cnt_width-1:0] wr_cycles;
  logic [perf_defs_pkg::cycle_cnt_width-1:0] rd_cycles;
  logic                                      tx_valid;
  logic [7:0]                                tx_data;
  logic                                      tx_ready;
  logic                                      busy;
  logic                                      gen_start;

  // a run lasts until its report has left the pin.
  assign gen_start = start && !busy;

  axi_traffic_gen axi_traffic_gen_i (
    .clk(clk), .rst_n(rst_n), .start(gen_start),
    .num_bursts(num_bursts), .burst_len(burst_len),
    .awvalid(awvalid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
    .awburst(awburst), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .arvalid(arvalid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
    .arburst(arburst), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rlast(rlast), .rresp(rresp), .rready(rready),
    .wr_phase(wr_phase), .rd_phase(rd_phase), .burst_done(burst_done),
    .beat_done(beat_done), .mismatch(mismatch), .run_done(run_done)
  );

  axi_burst_mem axi_burst_mem_i (
    .clk(clk), .rst_n(rst_n),
    .awvalid(awvalid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
    .awburst(awburst), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .arvalid(arvalid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
    .arburst(arburst), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rlast(rlast), .rresp(rresp), .rready(rready)
  );

  perf_counters perf_counters_i (
    .clk(clk), .rst_n(rst_n),
    .wr_phase(wr_phase), .rd_phase(rd_phase), .burst_done(burst_done),
    .beat_done(beat_done), .mismatch(mismatch), .run_done(run_done),
    .bursts(bursts), .beats(beats), .mismatches(mismatches),
    .wr_cycles(wr_cycles), .rd_cycles(rd_cycles), .report_start(report_start)
  );

  perf_reporter perf_reporter_i (
    .clk(clk), .rst_n(rst_n), .report_start(report_start),
    .bursts(bursts), .beats(beats), .mismatches(mismatches),
    .wr_cycles(wr_cycles), .rd_cycles(rd_cycles),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready), .busy(busy)
  );

  uart_tx uart_tx_i (
    .clk(clk), .rst_n(rst_n),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready), .txd(utx_pin)
  );

endmodule

`default_nettype wire

//--- rtl/axi_traffic_gen.sv
`timescale 1ns/1ps
`default_nettype none

module axi_traffic_gen (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     start,
  input  logic [3:0]                               num_bursts,
  input  logic [3:0]                               burst_len,
  output logic                                     awvalid,
  output logic [axi_defs_pkg::axi_addr_width-1:0]  awaddr,
  output logic [7:0]                               awlen,
  output logic [2:0]                               awsize,
  output logic [1:0]                               awburst,
  input  logic                                     awready,
  output logic                                     wvalid,
  output logic [axi_defs_pkg::axi_data_width-1:0]  wdata,
  output logic [axi_defs_pkg::axi_strb_width-1:0]  wstrb,
  output logic                                     wlast,
  input  logic                                     wready,
  input  logic                                     bvalid,
  input  logic [1:0]                               bresp,
  output logic                                     bready,
  output logic                                     arvalid,
  output logic [axi_defs_pkg::axi_addr_width-1:0]  araddr,
  output logic [7:0]                               arlen,
  output logic [2:0]                               arsize,
  output logic [1:0]                               arburst,
  input  logic                                     arready,
  input  logic                                     rvalid,
  input  logic [axi_defs_pkg::axi_data_width-1:0]  rdata,
  input  logic                                     rlast,
  input  logic [1:0]                               rresp,
  output logic                                     rready,
  output logic                                     wr_phase,
  output logic                                     rd_phase,
  output logic                                     burst_done,
  output logic                                     beat_done,
  output logic                                     mismatch,
  output logic                                     run_done
);

  enum logic [2:0] {S_IDLE, S_AW, S_W, S_B, S_AR, S_R} state;

  logic [3:0] nb;
  logic [3:0] bl;
  logic [3:0] bcnt;
  logic [3:0] beat;
  logic       last_burst;
  logic [axi_defs_pkg::axi_addr_width-1:0] base;
  logic [axi_defs_pkg::axi_addr_width-1:0] burst_bytes;
  logic [axi_defs_pkg::axi_data_width-1:0] lfsr;
  logic [axi_defs_pkg::axi_data_width-1:0] lfsr_next;

  assign lfsr_next   = lfsr[0] ? ((lfsr >> 1) ^ perf_defs_pkg::lfsr_taps) : (lfsr >> 1);
  assign burst_bytes = axi_defs_pkg::axi_addr_width'({bl, 1'b0}) + 2'd2;
  assign last_burst  = (bcnt == nb - 4'd1);

  assign awvalid = (state == S_AW);
  assign awaddr  = base;
  assign awlen   = {4'b0000, bl};
  assign awsize  = axi_defs_pkg::axi_size_full;
  assign awburst = axi_defs_pkg::axi_burst_incr;
  assign wvalid  = (state == S_W);
  assign wdata   = lfsr;
  assign wstrb   = '1;
  assign wlast   = (beat == bl);
  assign bready  = (state == S_B);
  assign arvalid = (state == S_AR);
  assign araddr  = base;
  assign arlen   = {4'b0000, bl};
  assign arsize  = axi_defs_pkg::axi_size_full;
  assign arburst = axi_defs_pkg::axi_burst_incr;
  assign rready  = 1'b1;

  assign wr_phase   = (state == S_AW) || (state == S_W) || (state == S_B);
  assign rd_phase   = (state == S_AR) || (state == S_R);
  assign burst_done = bvalid && bready;
  assign beat_done  = wvalid && wready;
  assign mismatch   = (state == S_R) && rvalid &&
                      (rdata != lfsr || rresp != axi_defs_pkg::axi_resp_okay);
  assign run_done   = (state == S_R) && rvalid && rlast && last_burst;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      nb    <= '0;
      bl    <= '0;
      bcnt  <= '0;
      beat  <= '0;
      base  <= '0;
      lfsr  <= perf_defs_pkg::lfsr_seed;
    end else begin
      case (state)
        S_IDLE: if (start) begin
          nb    <= num_bursts;
          bl    <= burst_len;
          bcnt  <= '0;
          base  <= '0;
          lfsr  <= perf_defs_pkg::lfsr_seed;
          state <= S_AW;
        end
        S_AW: if (awready) begin
          beat  <= '0;
          state <= S_W;
        end
        S_W: if (wready) begin
          lfsr <= lfsr_next;
          beat <= beat + 4'd1;
          if (wlast)
            state <= S_B;
        end
        S_B: if (bvalid) begin
          // the read phase starts over from the first burst and the seed.
          if (last_burst) begin
            bcnt  <= '0;
            base  <= '0;
            lfsr  <= perf_defs_pkg::lfsr_seed;
            state <= S_AR;
          end else begin
            bcnt  <= bcnt + 4'd1;
            base  <= base + burst_bytes;
            state <= S_AW;
          end
        end
        S_AR: if (arready)
          state <= S_R;
        S_R: if (rvalid) begin
          lfsr <= lfsr_next;
          if (rlast) begin
            bcnt  <= bcnt + 4'd1;
            base  <= base + burst_bytes;
            state <= last_burst ? S_IDLE : S_AR;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (awvalid && !awready) |=> (awvalid && $stable(awaddr) && $stable(awlen)));

  assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)));

  assert property (@(posedge clk) disable iff (!rst_n)
    (start && state == S_IDLE) |->
      (num_bursts >= 4'd1 && num_bursts <= axi_defs_pkg::max_bursts));

  // the memory never reports an error on a write.
  assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid && bready) |-> (bresp == axi_defs_pkg::axi_resp_okay));

endmodule

`default_nettype wire

//--- rtl/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      wr_phase,
  input  logic                                      rd_phase,
  input  logic                                      burst_done,
  input  logic                                      beat_done,
  input  logic                                      mismatch,
  input  logic                                      run_done,
  output logic [7:0]                                bursts,
  output logic [perf_defs_pkg::beat_cnt_width-1:0]  beats,
  output logic [perf_defs_pkg::beat_cnt_width-1:0]  mismatches,
  output logic [perf_defs_pkg::cycle_cnt_width-1:0] wr_cycles,
  output logic [perf_defs_pkg::cycle_cnt_width-1:0] rd_cycles,
  output logic                                      report_start
);

  logic wr_phase_q;
  logic frozen;
  logic run_begin;

  assign run_begin = wr_phase && !wr_phase_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_phase_q   <= 1'b0;
      frozen       <= 1'b0;
      report_start <= 1'b0;
      bursts       <= '0;
      beats        <= '0;
      mismatches   <= '0;
      wr_cycles    <= '0;
      rd_cycles    <= '0;
    end else begin
      wr_phase_q   <= wr_phase;
      report_start <= run_done;
      if (run_begin) begin
        // the first write cycle is already part of the phase.
        frozen     <= 1'b0;
        bursts     <= '0;
        beats      <= '0;
        mismatches <= '0;
        wr_cycles  <= perf_defs_pkg::cycle_cnt_width'(1);
        rd_cycles  <= '0;
      end else if (!frozen) begin
        if (burst_done)
          bursts <= bursts + 8'd1;
        if (beat_done)
          beats <= beats + 1'b1;
        if (mismatch)
          mismatches <= mismatches + 1'b1;
        if (wr_phase)
          wr_cycles <= wr_cycles + 1'b1;
        if (rd_phase)
          rd_cycles <= rd_cycles + 1'b1;
        if (run_done)
          frozen <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/perf_defs_pkg.sv
`default_nettype none

package perf_defs_pkg;

  // one UART bit lasts this many clock cycles.
  localparam int clks_per_bit = 16;

  localparam int cycle_cnt_width = 32;
  localparam int beat_cnt_width  = 16;

  // report frame layout.
  localparam logic [7:0] report_header = 8'hA5;
  localparam int         report_bytes  = 14;

  // data pattern for the write and read phases.
  localparam logic [15:0] lfsr_seed = 16'hACE1;
  localparam logic [15:0] lfsr_taps = 16'hB400;

endpackage

`default_nettype wire

//--- rtl/perf_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module perf_reporter (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      report_start,
  input  logic [7:0]                                bursts,
  input  logic [perf_defs_pkg::beat_cnt_width-1:0]  beats,
  input  logic [perf_defs_pkg::beat_cnt_width-1:0]  mismatches,
  input  logic [perf_defs_pkg::cycle_cnt_width-1:0] wr_cycles,
  input  logic [perf_defs_pkg::cycle_cnt_width-1:0] rd_cycles,
  output logic                                      tx_valid,
  output logic [7:0]                                tx_data,
  input  logic                                      tx_ready,
  output logic                                      busy
);

  logic [perf_defs_pkg::report_bytes*8-1:0]       frame;
  logic [$clog2(perf_defs_pkg::report_bytes)-1:0] idx;
  logic                                           sending;

  assign tx_valid = sending;
  assign tx_data  = frame[perf_defs_pkg::report_bytes*8-1 -: 8];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sending <= 1'b0;
      busy    <= 1'b0;
      idx     <= '0;
    end else if (report_start && !busy) begin
      sending <= 1'b1;
      busy    <= 1'b1;
      idx     <= '0;
    end else if (sending && tx_ready) begin
      idx <= idx + 1'b1;
      if (int'(idx) == perf_defs_pkg::report_bytes - 1)
        sending <= 1'b0;
    end else if (busy && !sending && tx_ready) begin
      // the transmitter is ready again once the last stop bit is out.
      busy <= 1'b0;
    end
  end

  // fields leave most significant byte first, so the frame shifts left.
  always_ff @(posedge clk) begin
    if (report_start && !busy)
      frame <= {perf_defs_pkg::report_header, bursts, beats, mismatches,
                wr_cycles, rd_cycles};
    else if (sending && tx_ready)
      frame <= frame << 8;
  end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       txd
);

  logic [$clog2(perf_defs_pkg::clks_per_bit)-1:0] baud;
  logic [3:0] nbit;
  logic [9:0] shreg;
  logic       active;

  assign tx_ready = !active;
  // the register idles at all ones, so the line rests high.
  assign txd = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      baud   <= '0;
      nbit   <= '0;
      shreg  <= '1;
    end else if (tx_valid && tx_ready) begin
      active <= 1'b1;
      baud   <= '0;
      nbit   <= '0;
      shreg  <= {1'b1, tx_data, 1'b0};
    end else if (active) begin
      if (int'(baud) == perf_defs_pkg::clks_per_bit - 1) begin
        baud  <= '0;
        shreg <= {1'b1, shreg[9:1]};
        if (nbit == 4'd9)
          active <= 1'b0;
        else
          nbit <= nbit + 4'd1;
      end else begin
        baud <= baud + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

`default_nettype wire

//--- sources.f
rtl/axi_defs_pkg.sv
rtl/perf_defs_pkg.sv
rtl/axi_burst_mem.sv
rtl/axi_traffic_gen.sv
rtl/perf_counters.sv
rtl/perf_reporter.sv
rtl/uart_tx.sv
rtl/axi_perf_mem.sv
tests/tb_axi_perf_mem.sv

//--- tests/tb_axi_perf_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_perf_mem;

  logic       clk;
  logic       rst_n;
  logic       start;
  logic [3:0] num_bursts;
  logic [3:0] burst_len;
  logic       utx_pin;
  int         value_errs;
  int         other_errs;

  axi_perf_mem UUT (
    .clk(clk), .rst_n(rst_n), .start(start),
    .num_bursts(num_bursts), .burst_len(burst_len), .utx_pin(utx_pin)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("errors: %0d value, %0d other", value_errs, other_errs + 1);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_beats(input string name,
                             input logic [perf_defs_pkg::beat_cnt_width-1:0] exp,
                             input logic [perf_defs_pkg::beat_cnt_width-1:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_cycles(input string name,
                              input logic [perf_defs_pkg::cycle_cnt_width-1:0] lo,
                              input logic [perf_defs_pkg::cycle_cnt_width-1:0] hi,
                              input logic [perf_defs_pkg::cycle_cnt_width-1:0] act);
    if ($isunknown(act) || act < lo || act > hi) begin
      $display("ERR %s expected %0d..%0d actual %0d", name, lo, hi, act);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name,
                            input logic [axi_defs_pkg::axi_data_width-1:0] exp,
                            input logic [axi_defs_pkg::axi_data_width-1:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  // one step of the Galois pattern generator, shifting toward bit 0.
  function automatic logic [15:0] lfsr_step(input logic [15:0] x);
    if (x[0])
      return (x >> 1) ^ perf_defs_pkg::lfsr_taps;
    return x >> 1;
  endfunction

  // the line is sampled on the falling clock edge, away from the driving edge.
  task automatic receive_byte(input int limit, output logic [7:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    while (utx_pin !== 1'b0) begin
      if (waited >= limit)
        stop_on_timeout("no start bit seen on utx_pin");
      waited++;
      @(negedge clk);
    end
    repeat (perf_defs_pkg::clks_per_bit / 2) @(negedge clk);
    if (utx_pin !== 1'b0) begin
      $display("start bit on utx_pin did not last to mid-bit");
      other_errs++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (perf_defs_pkg::clks_per_bit) @(negedge clk);
      data[i] = utx_pin;
    end
    repeat (perf_defs_pkg::clks_per_bit) @(negedge clk);
    if (utx_pin !== 1'b1) begin
      $display("stop bit on utx_pin is low");
      other_errs++;
    end
  endtask

  task automatic watch_idle_line(input int cycles, input string when);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (utx_pin !== 1'b1) begin
        $display("utx_pin went low %s", when);
        other_errs++;
        break;
      end
    end
  endtask

  task automatic run_once(input int run_idx, input int nb, input int bl);
    logic [7:0]  frame [perf_defs_pkg::report_bytes];
    logic [15:0] exp_beats;
    logic [15:0] pattern;
    logic [31:0] lo;
    logic [31:0] hi;
    string       tag;
    tag = $sformatf("run%0d", run_idx);
    exp_beats = 16'(nb * (bl + 1));
    @(posedge clk);
    num_bursts <= 4'(nb);
    burst_len  <= 4'(bl);
    start      <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // a second pulse while the generator is still in its write phase.
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    receive_byte(4000, frame[0]);
    for (int i = 1; i < perf_defs_pkg::report_bytes; i++)
      receive_byte(200, frame[i]);
    // and one more while the last stop bit is still on the line.
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    watch_idle_line(400, {"after the frame of ", tag});
    lo = 32'(exp_beats);
    hi = 32'(exp_beats) + 32'(4 * nb + 4);
    check_byte({tag, " header"}, perf_defs_pkg::report_header, frame[0]);
    check_byte({tag, " bursts"}, 8'(nb), frame[1]);
    check_beats({tag, " beats"}, exp_beats, {frame[2], frame[3]});
    check_beats({tag, " mismatches"}, '0, {frame[4], frame[5]});
    check_cycles({tag, " wr_cycles"}, lo, hi, {frame[6], frame[7], frame[8], frame[9]});
    check_cycles({tag, " rd_cycles"}, lo, hi, {frame[10], frame[11], frame[12], frame[13]});
    // the write pattern runs on across bursts, so word i holds step i.
    pattern = perf_defs_pkg::lfsr_seed;
    for (int i = 0; i < int'(exp_beats); i++) begin
      check_word($sformatf("%s mem[%0d]", tag, i), pattern, UUT.axi_burst_mem_i.mem[i]);
      pattern = lfsr_step(pattern);
    end
  endtask

  initial begin
    int nb;
    int bl;
    value_errs = 0;
    other_errs = 0;
    rst_n      = 1'b0;
    start      = 1'b0;
    num_bursts = 4'd1;
    burst_len  = 4'd0;
    void'($urandom(32'h878e6aec));
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    watch_idle_line(60, "before the first start");
    for (int run = 0; run < 12; run++) begin
      nb = 1 + int'($urandom % 8);
      bl = int'($urandom % 16);
      run_once(run, nb, bl);
    end
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
